/* dv/rv_core_prog.svh */
`ifndef RV_CORE_PROG_SVH
`define RV_CORE_PROG_SVH

// Columns: instruction word, expected reg_we, expected writeback value
// Memory rows give the instruction, the byte address and the store data

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic load_program();
    // Every ALU operation, immediate and register forms
    emit(i_type(12'h123, 0, F3_ADD_SUB, 1, OPC_OP_IMM), 1, 32'h0000_0123);
    emit(i_type(12'hffb, 0, F3_ADD_SUB, 2, OPC_OP_IMM), 1, 32'hffff_fffb);
    emit(r_type(F7_BASE, 2, 1, F3_ADD_SUB, 3), 1, 32'h0000_011e);
    emit(r_type(F7_ALT, 2, 1, F3_ADD_SUB, 4), 1, 32'h0000_0128);
    emit(i_type(12'h004, 1, F3_SLL, 5, OPC_OP_IMM), 1, 32'h0000_1230);
    emit(r_type(F7_BASE, 4, 1, F3_SLL, 6), 1, 32'h0001_2300);
    emit(i_type(12'hffc, 2, F3_SLT, 7, OPC_OP_IMM), 1, 32'h0000_0001);
    emit(r_type(F7_BASE, 2, 1, F3_SLT, 8), 1, 32'h0000_0000);
    emit(i_type(12'hfff, 1, F3_SLTU, 9, OPC_OP_IMM), 1, 32'h0000_0001);
    emit(r_type(F7_BASE, 2, 1, F3_SLTU, 10), 1, 32'h0000_0001);
    emit(i_type(12'h0ff, 1, F3_XOR, 11, OPC_OP_IMM), 1, 32'h0000_01dc);
    emit(r_type(F7_BASE, 2, 1, F3_XOR, 12), 1, 32'hffff_fed8);
    emit(i_type(12'h004, 2, F3_SRL_SRA, 13, OPC_OP_IMM), 1, 32'h0fff_ffff);
    emit(i_type(12'h401, 2, F3_SRL_SRA, 14, OPC_OP_IMM), 1, 32'hffff_fffd);
    emit(r_type(F7_BASE, 4, 2, F3_SRL_SRA, 15), 1, 32'h00ff_ffff);
    emit(r_type(F7_ALT, 4, 2, F3_SRL_SRA, 16), 1, 32'hffff_ffff);
    emit(i_type(12'h400, 1, F3_OR, 17, OPC_OP_IMM), 1, 32'h0000_0523);
    emit(r_type(F7_BASE, 4, 1, F3_OR, 18), 1, 32'h0000_012b);
    emit(i_type(12'h0f0, 2, F3_AND, 19, OPC_OP_IMM), 1, 32'h0000_00f0);
    emit(r_type(F7_BASE, 2, 1, F3_AND, 20), 1, 32'h0000_0123);
    emit(u_type(20'h12345, 21, OPC_LUI), 1, 32'h1234_5000);
    emit(u_type(20'h00001, 22, OPC_AUIPC), 1, place_pc + 32'h1000);

    // Branches alternate taken and not taken, skipped words never retire
    emit(b_type(13'd8, 1, 1, F3_BEQ), 0, 0);
    place(i_type(12'h001, 0, F3_ADD_SUB, 31, OPC_OP_IMM));
    emit(b_type(13'd8, 1, 1, F3_BNE), 0, 0);
    emit(b_type(13'd8, 1, 2, F3_BLT), 0, 0);
    place(i_type(12'h002, 0, F3_ADD_SUB, 31, OPC_OP_IMM));
    emit(b_type(13'd8, 1, 2, F3_BGE), 0, 0);
    emit(b_type(13'd8, 2, 1, F3_BLTU), 0, 0);
    place(i_type(12'h003, 0, F3_ADD_SUB, 31, OPC_OP_IMM));
    emit(b_type(13'd8, 2, 1, F3_BGEU), 0, 0);
    emit(j_type(21'd8, 23), 1, place_pc + 32'd4);
    place(i_type(12'h004, 0, F3_ADD_SUB, 31, OPC_OP_IMM));
    emit(u_type(20'h00000, 24, OPC_AUIPC), 1, place_pc);
    // Odd offset, the target drops bit 0 and lands two words ahead
    emit(i_type(12'd17, 24, 3'b000, 25, OPC_JALR), 1, place_pc + 32'd4);
    place(i_type(12'h005, 0, F3_ADD_SUB, 31, OPC_OP_IMM));
    place(i_type(12'h006, 0, F3_ADD_SUB, 31, OPC_OP_IMM));

    // Stores, then loads of the stored lanes and of the random fill
    emit(i_type(12'h100, 0, F3_ADD_SUB, 26, OPC_OP_IMM), 1, 32'h0000_0100);
    access(s_type(12'd0, 12, 26, F3_WORD), 32'h100, 32'hffff_fed8);
    access(s_type(12'd6, 1, 26, F3_HALF), 32'h106, 32'h0000_0123);
    access(s_type(12'd9, 11, 26, F3_BYTE), 32'h109, 32'h0000_01dc);
    access(i_type(12'h000, 26, F3_WORD, 27, OPC_LOAD), 32'h100, 0);
    access(i_type(12'h006, 26, F3_HALF, 28, OPC_LOAD), 32'h106, 0);
    access(i_type(12'h009, 26, F3_BYTE, 29, OPC_LOAD), 32'h109, 0);
    access(i_type(12'h021, 26, F3_BYTEU, 30, OPC_LOAD), 32'h121, 0);
    access(i_type(12'h042, 26, F3_HALFU, 31, OPC_LOAD), 32'h142, 0);
    access(i_type(12'h083, 26, F3_BYTE, 27, OPC_LOAD), 32'h183, 0);
    access(i_type(12'h0c2, 26, F3_HALF, 28, OPC_LOAD), 32'h1c2, 0);

    // x0 write and read back, then illegal word, FENCE and ECALL
    emit(u_type(20'h55555, 0, OPC_LUI), 1, 32'h5555_5000);
    emit(r_type(F7_BASE, 0, 0, F3_ADD_SUB, 27), 1, 32'h0000_0000);
    emit(32'hffff_ffff, 0, 0, 1'b1);
    emit(32'h0ff0_000f, 0, 0);
    emit(32'h0000_0073, 0, 0);
    emit(i_type(12'h7ff, 27, F3_ADD_SUB, 1, OPC_OP_IMM), 1, 32'h0000_07ff);
endtask

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;

    import rv_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0080;
    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam int RETIRE_TIMEOUT = 20;
    localparam logic [1:0] MEM_NONE = 2'd0;
    localparam logic [1:0] MEM_LOAD = 2'd1;
    localparam logic [1:0] MEM_STORE = 2'd2;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] insn;
        logic [4:0]  rd;
        logic        reg_we;
        logic [31:0] wdata;
        logic        illegal;
        logic [1:0]  mem;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [31:0] sdata;
    } exp_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] imem_idx;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    retire_t     retire;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:255];
    logic [31:0] ref_mem [0:255];
    exp_t        exp_q [$];
    logic [31:0] place_pc;
    integer      seed;
    int          cyc = 0;
    int          retired = 0;
    int          flow_errs = 0;
    int          data_errs = 0;
    int          mem_errs = 0;
    int          other_errs = 0;

    rv_core #(.RESET_PC(RESET_PC)) UUT (
        .clk_i(clk), .arst_n_i(arst_n),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_req_o(dmem_req), .dmem_rdata_i(dmem_rdata),
        .retire_o(retire)
    );

    function automatic logic [3:0] lane_mask(input logic [2:0] f3, input logic [31:0] addr);
        case (f3[1:0])
            2'b00:   return 4'b0001 << addr[1:0];
            2'b01:   return 4'b0011 << addr[1:0];
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_data(input logic [2:0] f3, input logic [31:0] d);
        case (f3[1:0])
            2'b00:   return {4{d[7:0]}};
            2'b01:   return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    // Expected load result from the reference copy of memory
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        w = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
        case (f3)
            F3_BYTE:  return {{24{w[7]}}, w[7:0]};
            F3_HALF:  return {{16{w[15]}}, w[15:0]};
            F3_BYTEU: return {24'd0, w[7:0]};
            F3_HALFU: return {16'd0, w[15:0]};
            default:  return w;
        endcase
    endfunction

    task automatic place(input logic [31:0] insn);
        imem[(place_pc - RESET_PC) >> 2] = insn;
        place_pc += 32'd4;
    endtask

    task automatic emit(input logic [31:0] insn, input logic we, input logic [31:0] wdata,
                        input logic illegal = 1'b0);
        exp_t e;
        e = '0;
        e.pc = place_pc;
        e.insn = insn;
        e.rd = insn[11:7];
        e.reg_we = we;
        e.wdata = wdata;
        e.illegal = illegal;
        exp_q.push_back(e);
        place(insn);
    endtask

    task automatic access(input logic [31:0] insn, input logic [31:0] addr,
                          input logic [31:0] sdata);
        exp_t e;
        e = '0;
        e.pc = place_pc;
        e.insn = insn;
        e.rd = insn[11:7];
        e.f3 = insn[14:12];
        e.addr = addr;
        e.sdata = sdata;
        if (insn[6:0] == OPC_STORE) begin
            e.mem = MEM_STORE;
            ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], lane_data(e.f3, sdata),
                                             lane_mask(e.f3, addr));
        end else begin
            e.mem = MEM_LOAD;
            e.reg_we = 1'b1;
            e.wdata = load_value(e.f3, addr);
        end
        exp_q.push_back(e);
        place(insn);
    endtask

`include "rv_core_prog.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both memories answer in the same cycle
    assign imem_idx = (imem_addr - RESET_PC) >> 2;
    assign imem_data = (imem_idx < 32'd64) ? imem[imem_idx[5:0]] : NOP;
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (arst_n && dmem_req.strobe && dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= merge_bytes(dmem[dmem_req.addr[9:2]],
                                                    dmem_req.wdata, dmem_req.be);
        end
        if (arst_n) begin
            cyc <= cyc + 1;
        end
    end

    // Cycle cyc executes entry cyc and shows the retire record of entry cyc-1
    always @(negedge clk) begin : check_cycle
        exp_t e;
        if (!arst_n) begin
            assert (!retire.valid && !dmem_req.strobe && imem_addr == RESET_PC) else begin
                $display("mismatch %0t: state during reset not cleared", $time);
                other_errs++;
            end
        end else begin
            if (cyc < exp_q.size()) begin
                e = exp_q[cyc];
                assert (imem_addr == e.pc) else begin
                    $display("mismatch %0t: fetch pc %h, expected %h", $time, imem_addr, e.pc);
                    flow_errs++;
                end
                assert (dmem_req.strobe == (e.mem != MEM_NONE)) else begin
                    $display("mismatch %0t: strobe %b at pc %h", $time, dmem_req.strobe, e.pc);
                    mem_errs++;
                end
                if (e.mem != MEM_NONE) begin
                    assert (dmem_req.we == (e.mem == MEM_STORE) && dmem_req.addr == e.addr &&
                            dmem_req.be == lane_mask(e.f3, e.addr)) else begin
                        $display("mismatch %0t: request we %b addr %h be %b at pc %h", $time,
                                 dmem_req.we, dmem_req.addr, dmem_req.be, e.pc);
                        mem_errs++;
                    end
                end
                if (e.mem == MEM_STORE) begin
                    assert (dmem_req.wdata == lane_data(e.f3, e.sdata)) else begin
                        $display("mismatch %0t: store data %h at pc %h", $time,
                                 dmem_req.wdata, e.pc);
                        mem_errs++;
                    end
                end
            end
            if (cyc == 0) begin
                assert (!retire.valid) else begin
                    $display("mismatch %0t: retire valid before first instruction", $time);
                    other_errs++;
                end
            end else if (cyc <= exp_q.size()) begin
                e = exp_q[cyc - 1];
                assert (retire.valid && retire.pc == e.pc) else begin
                    $display("mismatch %0t: retire pc %h valid %b, expected %h", $time,
                             retire.pc, retire.valid, e.pc);
                    flow_errs++;
                end
                assert (retire.insn == e.insn) else begin
                    $display("mismatch %0t: retire insn %h, expected %h at pc %h", $time,
                             retire.insn, e.insn, e.pc);
                    flow_errs++;
                end
                assert (retire.reg_we == e.reg_we && retire.illegal == e.illegal) else begin
                    $display("mismatch %0t: reg_we %b illegal %b at pc %h", $time,
                             retire.reg_we, retire.illegal, e.pc);
                    data_errs++;
                end
                if (e.reg_we) begin
                    assert (retire.rd == e.rd && retire.wdata == e.wdata) else begin
                        $display("mismatch %0t: x%0d = %h, expected x%0d = %h at pc %h", $time,
                                 retire.rd, retire.wdata, e.rd, e.wdata, e.pc);
                        data_errs++;
                    end
                end
                retired = cyc;
            end
        end
    end

    initial begin : main
        int waited;
        arst_n = 1'b0;
        seed = 32'hd142_4efa;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
            ref_mem[i] = dmem[i];
        end
        // ADDI x0, x0, index in every unused word
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP | (i << 20);
        end
        place_pc = RESET_PC;
        load_program();

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < exp_q.size(); i++) begin
            waited = 0;
            while (retired <= i && waited < RETIRE_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (retired <= i) begin
                $display("timeout: instruction %0d never retired", i);
                other_errs++;
                break;
            end
        end

        $display("errors: flow %0d, data %0d, memory %0d, other %0d",
                 flow_errs, data_errs, mem_errs, other_errs);
        if (flow_errs + data_errs + mem_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+dv
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_branch_unit.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
dv/rv_core_tb.sv

/* verilog/rv_alu.sv */
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     result_o
);

    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {31'd0, a_i < b_i};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = 32'd0;
        endcase
    end

endmodule

/* verilog/rv_branch_unit.sv */
`timescale 1ns/1ns

module rv_branch_unit (
    input  rv_pkg::br_op_e op_i,
    input  logic [31:0]    rs1_i,
    input  logic [31:0]    rs2_i,
    input  logic [31:0]    pc_i,
    input  logic [31:0]    imm_i,
    input  logic [31:0]    alu_sum_i,
    output logic           taken_o,
    output logic [31:0]    target_o
);

    import rv_pkg::*;

    always_comb begin
        case (op_i)
            BR_BEQ:           taken_o = (rs1_i == rs2_i);
            BR_BNE:           taken_o = (rs1_i != rs2_i);
            BR_BLT:           taken_o = ($signed(rs1_i) < $signed(rs2_i));
            BR_BGE:           taken_o = ($signed(rs1_i) >= $signed(rs2_i));
            BR_BLTU:          taken_o = (rs1_i < rs2_i);
            BR_BGEU:          taken_o = (rs1_i >= rs2_i);
            BR_JAL, BR_JALR:  taken_o = 1'b1;
            default:          taken_o = 1'b0;
        endcase
    end

    // JALR target is rs1 + imm from the ALU, LSB forced low
    assign target_o = (op_i == BR_JALR) ? {alu_sum_i[31:1], 1'b0} : pc_i + imm_i;

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ns

module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    output logic [31:0]       imem_addr_o,
    input  logic [31:0]       imem_data_i,
    output rv_pkg::dmem_req_t dmem_req_o,
    input  logic [31:0]       dmem_rdata_i,
    output rv_pkg::retire_t   retire_o
);

    import rv_pkg::*;

    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] load_data;
    logic [31:0] wb_data;

    assign imem_addr_o = pc_q;
    assign pc_plus4 = pc_q + 32'd4;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= br_taken ? br_target : pc_plus4;
        end
    end

    rv_decoder u_decoder (.instr_i(imem_data_i), .ctrl_o(ctrl), .imm_o(imm));

    rv_regfile u_regfile (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .raddr1_i(ctrl.rs1), .raddr2_i(ctrl.rs2),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data),
        .we_i(ctrl.reg_we), .waddr_i(ctrl.rd), .wdata_i(wb_data)
    );

    always_comb begin
        case (ctrl.op_a_sel)
            OPA_PC:   op_a = pc_q;
            OPA_ZERO: op_a = 32'd0;
            default:  op_a = rs1_data;
        endcase
        op_b = (ctrl.op_b_sel == OPB_IMM) ? imm : rs2_data;
    end

    rv_alu u_alu (.op_i(ctrl.alu_op), .a_i(op_a), .b_i(op_b), .result_o(alu_result));

    rv_branch_unit u_branch (
        .op_i(ctrl.br_op), .rs1_i(rs1_data), .rs2_i(rs2_data), .pc_i(pc_q),
        .imm_i(imm), .alu_sum_i(alu_result), .taken_o(br_taken), .target_o(br_target)
    );

    rv_lsu u_lsu (
        .op_i(ctrl.lsu_op), .addr_i(alu_result), .store_data_i(rs2_data),
        .dmem_req_o(dmem_req_o), .dmem_rdata_i(dmem_rdata_i), .load_data_o(load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // Trace record trails execution by one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_o <= '0;
        end else begin
            retire_o.valid <= 1'b1;
            retire_o.pc <= pc_q;
            retire_o.insn <= imem_data_i;
            retire_o.rd <= ctrl.rd;
            retire_o.reg_we <= ctrl.reg_we;
            retire_o.wdata <= wb_data;
            retire_o.illegal <= ctrl.illegal;
        end
    end

endmodule

/* verilog/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder (
    input  logic [31:0]   instr_i,
    output rv_pkg::ctrl_t ctrl_o,
    output logic [31:0]   imm_o
);

    import rv_pkg::*;

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o = '0;
        imm_o = '0;

        case (opcode_e'(instr_i[6:0]))
            OPC_OP_IMM: begin
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                imm_o = imm_i;
                case (funct3)
                    F3_ADD_SUB: ctrl_o.alu_op = ALU_ADD;
                    F3_SLT:     ctrl_o.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl_o.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl_o.alu_op = ALU_XOR;
                    F3_OR:      ctrl_o.alu_op = ALU_OR;
                    F3_AND:     ctrl_o.alu_op = ALU_AND;
                    F3_SLL: begin
                        ctrl_o.alu_op = ALU_SLL;
                        ctrl_o.illegal = (funct7 != F7_BASE);
                    end
                    default: begin
                        ctrl_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        ctrl_o.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    end
                endcase
                // Shift amount lives in the low five bits only
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    imm_o = imm_i & 32'h1f;
                end
            end
            OPC_OP: begin
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rs2 = instr_i[24:20];
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                case (funct3)
                    F3_ADD_SUB: ctrl_o.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl_o.alu_op = ALU_SLL;
                    F3_SLT:     ctrl_o.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl_o.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl_o.alu_op = ALU_OR;
                    default:    ctrl_o.alu_op = ALU_AND;
                endcase
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                ctrl_o.illegal = (funct7 != F7_BASE) &&
                                 !((funct7 == F7_ALT) &&
                                   (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_LUI: begin
                ctrl_o.op_a_sel = OPA_ZERO;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                imm_o = imm_u;
            end
            OPC_AUIPC: begin
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                imm_o = imm_u;
            end
            OPC_JAL: begin
                ctrl_o.br_op = BR_JAL;
                ctrl_o.wb_sel = WB_PC4;
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                imm_o = imm_j;
            end
            OPC_JALR: begin
                ctrl_o.br_op = BR_JALR;
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.wb_sel = WB_PC4;
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                ctrl_o.illegal = (funct3 != 3'b000);
                imm_o = imm_i;
            end
            OPC_BRANCH: begin
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rs2 = instr_i[24:20];
                imm_o = imm_b;
                case (funct3)
                    F3_BEQ:  ctrl_o.br_op = BR_BEQ;
                    F3_BNE:  ctrl_o.br_op = BR_BNE;
                    F3_BLT:  ctrl_o.br_op = BR_BLT;
                    F3_BGE:  ctrl_o.br_op = BR_BGE;
                    F3_BLTU: ctrl_o.br_op = BR_BLTU;
                    F3_BGEU: ctrl_o.br_op = BR_BGEU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.wb_sel = WB_LOAD;
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rd = instr_i[11:7];
                ctrl_o.reg_we = 1'b1;
                imm_o = imm_i;
                case (funct3)
                    F3_BYTE:  ctrl_o.lsu_op = LSU_LB;
                    F3_HALF:  ctrl_o.lsu_op = LSU_LH;
                    F3_WORD:  ctrl_o.lsu_op = LSU_LW;
                    F3_BYTEU: ctrl_o.lsu_op = LSU_LBU;
                    F3_HALFU: ctrl_o.lsu_op = LSU_LHU;
                    default:  ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                ctrl_o.op_b_sel = OPB_IMM;
                ctrl_o.rs1 = instr_i[19:15];
                ctrl_o.rs2 = instr_i[24:20];
                imm_o = imm_s;
                case (funct3)
                    F3_BYTE: ctrl_o.lsu_op = LSU_SB;
                    F3_HALF: ctrl_o.lsu_op = LSU_SH;
                    F3_WORD: ctrl_o.lsu_op = LSU_SW;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            // FENCE, ECALL, EBREAK and CSR accesses behave as NOPs
            OPC_MISC_MEM, OPC_SYSTEM: begin
            end
            default: ctrl_o.illegal = 1'b1;
        endcase

        // Illegal words fall through as a NOP so the PC simply advances
        if (ctrl_o.illegal) begin
            ctrl_o = '0;
            ctrl_o.illegal = 1'b1;
            imm_o = '0;
        end
    end

endmodule

/* verilog/rv_lsu.sv */
`timescale 1ns/1ns

module rv_lsu (
    input  rv_pkg::lsu_op_e   op_i,
    input  logic [31:0]       addr_i,
    input  logic [31:0]       store_data_i,
    output rv_pkg::dmem_req_t dmem_req_o,
    input  logic [31:0]       dmem_rdata_i,
    output logic [31:0]       load_data_o
);

    import rv_pkg::*;

    logic [1:0]  offset;
    logic [31:0] lane_data;

    assign offset = addr_i[1:0];
    // Addressed byte or halfword moved down to bit 0
    assign lane_data = dmem_rdata_i >> {offset, 3'b000};

    always_comb begin
        dmem_req_o = '0;
        case (op_i)
            LSU_SB: begin
                dmem_req_o.we = 1'b1;
                dmem_req_o.wdata = {4{store_data_i[7:0]}};
                dmem_req_o.be = 4'b0001 << offset;
            end
            LSU_SH: begin
                dmem_req_o.we = 1'b1;
                dmem_req_o.wdata = {2{store_data_i[15:0]}};
                dmem_req_o.be = 4'b0011 << offset;
            end
            LSU_SW: begin
                dmem_req_o.we = 1'b1;
                dmem_req_o.wdata = store_data_i;
                dmem_req_o.be = 4'b1111;
            end
            LSU_LB, LSU_LBU: dmem_req_o.be = 4'b0001 << offset;
            LSU_LH, LSU_LHU: dmem_req_o.be = 4'b0011 << offset;
            LSU_LW:          dmem_req_o.be = 4'b1111;
            default: begin
            end
        endcase
        dmem_req_o.strobe = (op_i != LSU_NONE);
        dmem_req_o.addr = dmem_req_o.strobe ? addr_i : 32'd0;
    end

    always_comb begin
        case (op_i)
            LSU_LB:  load_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
            LSU_LH:  load_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
            LSU_LW:  load_data_o = dmem_rdata_i;
            LSU_LBU: load_data_o = {24'd0, lane_data[7:0]};
            LSU_LHU: load_data_o = {16'd0, lane_data[15:0]};
            default: load_data_o = 32'd0;
        endcase
    end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store width, bit 2 marks unsigned loads
    localparam logic [2:0] F3_BYTE  = 3'b000;
    localparam logic [2:0] F3_HALF  = 3'b001;
    localparam logic [2:0] F3_WORD  = 3'b010;
    localparam logic [2:0] F3_BYTEU = 3'b100;
    localparam logic [2:0] F3_HALFU = 3'b101;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e;
    typedef enum logic {OPB_RS2, OPB_IMM} op_b_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        lsu_op_e   lsu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        wb_sel_e   wb_sel;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       reg_we;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic        strobe;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } dmem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] insn;
        logic [4:0]  rd;
        logic        reg_we;
        logic [31:0] wdata;
        logic        illegal;
    } retire_t;

endpackage

/* verilog/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule
